// ==== axis_pkg.sv ====
/*
 * axis stream field widths
 * sizes of tdata, tuser, tkeep and the sideband info word that travels
 * with every beat through the router
 */
package axis_pkg;

    // payload
    localparam int DATA_W = 32;          // tdata bits

    // one keep bit per data byte
    localparam int KEEP_W = DATA_W / 8;

    // sideband user bits, carried untouched
    localparam int USER_W = 4;

    // info word sampled with each beat at s00
    // and handed out on the chosen master port
    localparam int INFO_W = 16;

    // tlast is a single bit and has no width constant

endpackage

// ==== route_pkg.sv ====
/*
 * routing constants
 * number of master ports, address width and the width of the flat word
 * that the routing core moves around
 */
package route_pkg;

    import axis_pkg::*;

    // master streams behind the router
    localparam int NUM_PORTS = 4;

    // port select, sampled on first beat of a packet
    localparam int ADDR_W = $clog2(NUM_PORTS);

    // flat word: data + last + user + keep + info
    localparam int PIPE_W = DATA_W + 1 + USER_W + KEEP_W + INFO_W;

endpackage

// ==== pipe_skid_buffer.sv ====
/*
 * two-entry register slice
 * main register plus skid register, ready is registered so there is no
 * combinational path from m_ready back to s_ready, full throughput kept
 */
`timescale 1ns/1ps

module pipe_skid_buffer #(
    parameter int WIDTH = route_pkg::PIPE_W + route_pkg::ADDR_W
) (
    input  logic             aclk,
    input  logic             arst_n,
    input  logic             aclken,
    input  logic             s_valid,
    input  logic [WIDTH-1:0] s_data,
    output logic             s_ready,
    output logic             m_valid,
    output logic [WIDTH-1:0] m_data,
    input  logic             m_ready
);

    logic             skid_valid;   // extra beat parked
    logic [WIDTH-1:0] skid_data;
    logic             s_xfer;       // beat accepted this cycle
    logic             main_free;    // main reg can take a new word
    logic             skid_next;

    assign s_xfer    = s_valid & s_ready;
    assign main_free = m_ready | ~m_valid;

    // skid holds while main is stuck, fills when a beat lands on a stuck main
    assign skid_next = skid_valid ? ~main_free : (s_xfer & ~main_free);

    // control
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid    <= 1'b0;
            skid_valid <= 1'b0;
            s_ready    <= 1'b0;     // comes up on first enabled edge
        end else if (aclken) begin
            if (main_free) begin
                m_valid <= skid_valid | s_xfer;     // skid drains first
            end
            skid_valid <= skid_next;
            s_ready    <= ~skid_next;               // open while skid empty
        end
    end

    // payload
    always_ff @(posedge aclk) begin
        if (aclken) begin
            if (main_free) begin
                if (skid_valid) begin
                    m_data <= skid_data;    // older beat goes out first
                end else if (s_xfer) begin
                    m_data <= s_data;
                end
            end
            if (s_xfer && !main_free) begin
                skid_data <= s_data;        // catch the beat in flight
            end
        end
    end

endmodule

// ==== data_pipe_interconnect_s2m.sv ====
/*
 * one-to-many flat word router
 * input slice, per-packet path lock on the first beat, demux to
 * NUM_PORTS output slices with ready steered back from the locked one
 */
`timescale 1ns/1ps

module data_pipe_interconnect_s2m (
    input  logic                            aclk,
    input  logic                            arst_n,
    input  logic                            aclken,
    input  logic [route_pkg::ADDR_W-1:0]    addr,       // with s_data
    input  logic                            s_valid,
    input  logic [route_pkg::PIPE_W-1:0]    s_data,
    output logic                            s_ready,
    output logic [route_pkg::NUM_PORTS-1:0] m_valid,
    output logic [route_pkg::PIPE_W-1:0]    m_data [route_pkg::NUM_PORTS],
    input  logic [route_pkg::NUM_PORTS-1:0] m_ready
);

    import axis_pkg::*;
    import route_pkg::*;

    logic                     in_valid;     // input slice output side
    logic                     in_ready;
    logic [PIPE_W+ADDR_W-1:0] in_word;
    logic [PIPE_W-1:0]        in_data;
    logic [ADDR_W-1:0]        in_addr;      // addr that came with this beat
    logic                     in_last;
    logic                     in_xfer;

    logic [ADDR_W-1:0]        path;         // locked port
    logic                     in_packet;    // middle of a packet
    logic [ADDR_W-1:0]        sel;

    logic [NUM_PORTS-1:0]     out_valid;
    logic [NUM_PORTS-1:0]     out_ready;

    // input slice carries addr next to the word
    pipe_skid_buffer #(
        .WIDTH   (PIPE_W + ADDR_W)
    ) u_in_slice (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .aclken  (aclken),
        .s_valid (s_valid),
        .s_data  ({addr, s_data}),
        .s_ready (s_ready),
        .m_valid (in_valid),
        .m_data  (in_word),
        .m_ready (in_ready)
    );

    assign in_data = in_word[PIPE_W-1:0];
    assign in_addr = in_word[PIPE_W +: ADDR_W];
    assign in_last = in_data[DATA_W];           // tlast sits right above tdata
    assign in_xfer = aclken & in_valid & in_ready;

    // first beat routes by its own addr, later beats follow the lock
    assign sel      = in_packet ? path : in_addr;
    assign in_ready = out_ready[sel];

    // path lock
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            path      <= '0;
            in_packet <= 1'b0;
        end else if (in_xfer) begin
            if (!in_packet) begin
                path <= in_addr;        // latch on first beat
            end
            in_packet <= ~in_last;      // release after tlast
        end
    end

    // demux into per-port slices
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_out
        assign out_valid[i] = in_valid & (sel == ADDR_W'(i));

        pipe_skid_buffer #(
            .WIDTH   (PIPE_W)
        ) u_out_slice (
            .aclk    (aclk),
            .arst_n  (arst_n),
            .aclken  (aclken),
            .s_valid (out_valid[i]),
            .s_data  (in_data),
            .s_ready (out_ready[i]),
            .m_valid (m_valid[i]),
            .m_data  (m_data[i]),
            .m_ready (m_ready[i])
        );
    end

endmodule

// ==== axis_interconnect_s2m_with_info.sv ====
/*
 * axi-stream one-to-many router with info word
 * packs tdata, tlast, tuser, tkeep and info into one flat word,
 * routes it, and slices it back apart on every master port
 */
`timescale 1ns/1ps

module axis_interconnect_s2m_with_info (
    input  logic                            aclk,
    input  logic                            arst_n,
    input  logic                            aclken,
    input  logic [route_pkg::ADDR_W-1:0]    addr,       // sync s00
    input  logic [axis_pkg::INFO_W-1:0]     in_info,    // sync s00
    input  logic                            s00_tvalid,
    input  logic [axis_pkg::DATA_W-1:0]     s00_tdata,
    input  logic                            s00_tlast,
    input  logic [axis_pkg::USER_W-1:0]     s00_tuser,
    input  logic [axis_pkg::KEEP_W-1:0]     s00_tkeep,
    output logic                            s00_tready,
    output logic [axis_pkg::INFO_W-1:0]     out_info   [route_pkg::NUM_PORTS],
    output logic [route_pkg::NUM_PORTS-1:0] m00_tvalid,
    output logic [axis_pkg::DATA_W-1:0]     m00_tdata  [route_pkg::NUM_PORTS],
    output logic [route_pkg::NUM_PORTS-1:0] m00_tlast,
    output logic [axis_pkg::USER_W-1:0]     m00_tuser  [route_pkg::NUM_PORTS],
    output logic [axis_pkg::KEEP_W-1:0]     m00_tkeep  [route_pkg::NUM_PORTS],
    input  logic [route_pkg::NUM_PORTS-1:0] m00_tready
);

    import axis_pkg::*;
    import route_pkg::*;

    logic [PIPE_W-1:0] s_word;
    logic [PIPE_W-1:0] m_word [NUM_PORTS];

    // lsb first: data, last, user, keep, info
    assign s_word = {in_info, s00_tkeep, s00_tuser, s00_tlast, s00_tdata};

    data_pipe_interconnect_s2m u_pipe (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .aclken  (aclken),
        .addr    (addr),
        .s_valid (s00_tvalid),
        .s_data  (s_word),
        .s_ready (s00_tready),
        .m_valid (m00_tvalid),
        .m_data  (m_word),
        .m_ready (m00_tready)
    );

    // unpack per port
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_unpack
        assign m00_tdata[i] = m_word[i][DATA_W-1:0];
        assign m00_tlast[i] = m_word[i][DATA_W];
        assign m00_tuser[i] = m_word[i][DATA_W+1 +: USER_W];
        assign m00_tkeep[i] = m_word[i][DATA_W+1+USER_W +: KEEP_W];
        assign out_info[i]  = m_word[i][DATA_W+1+USER_W+KEEP_W +: INFO_W];  // top field
    end

endmodule

// ==== axis_route_top.sv ====
/*
 * router top level
 * loose axi-stream ports around the one-to-many interconnect
 */
`timescale 1ns/1ps

module axis_route_top (
    input  logic                            aclk,
    input  logic                            arst_n,
    input  logic                            aclken,
    input  logic [route_pkg::ADDR_W-1:0]    addr,
    input  logic [axis_pkg::INFO_W-1:0]     in_info,
    input  logic                            s00_tvalid,
    input  logic [axis_pkg::DATA_W-1:0]     s00_tdata,
    input  logic                            s00_tlast,
    input  logic [axis_pkg::USER_W-1:0]     s00_tuser,
    input  logic [axis_pkg::KEEP_W-1:0]     s00_tkeep,
    output logic                            s00_tready,
    output logic [axis_pkg::INFO_W-1:0]     out_info   [route_pkg::NUM_PORTS],
    output logic [route_pkg::NUM_PORTS-1:0] m00_tvalid,
    output logic [axis_pkg::DATA_W-1:0]     m00_tdata  [route_pkg::NUM_PORTS],
    output logic [route_pkg::NUM_PORTS-1:0] m00_tlast,
    output logic [axis_pkg::USER_W-1:0]     m00_tuser  [route_pkg::NUM_PORTS],
    output logic [axis_pkg::KEEP_W-1:0]     m00_tkeep  [route_pkg::NUM_PORTS],
    input  logic [route_pkg::NUM_PORTS-1:0] m00_tready
);

    // single slave stream in, NUM_PORTS master streams out
    axis_interconnect_s2m_with_info u_route (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .aclken     (aclken),       // stalls the whole pipe
        .addr       (addr),
        .in_info    (in_info),
        .s00_tvalid (s00_tvalid),
        .s00_tdata  (s00_tdata),
        .s00_tlast  (s00_tlast),
        .s00_tuser  (s00_tuser),
        .s00_tkeep  (s00_tkeep),
        .s00_tready (s00_tready),
        .out_info   (out_info),
        .m00_tvalid (m00_tvalid),
        .m00_tdata  (m00_tdata),
        .m00_tlast  (m00_tlast),
        .m00_tuser  (m00_tuser),
        .m00_tkeep  (m00_tkeep),
        .m00_tready (m00_tready)
    );

endmodule

// ==== tb_axis_route.sv ====
/*
 * testbench for the axi-stream one-to-many router
 * lfsr driven packets with random addr, back-pressure and aclken gaps,
 * reference routing on first-beat addr, per-port scoreboard queues
 */
`timescale 1ns/1ps

module tb_axis_route;

    import axis_pkg::*;
    import route_pkg::*;

    localparam logic [31:0] SEED = 32'ha22d_2aa4;

    // expected beat, as the reference function builds it
    typedef struct packed {
        logic [ADDR_W-1:0] port;
        logic [INFO_W-1:0] info;
        logic [KEEP_W-1:0] keep;
        logic [USER_W-1:0] user;
        logic              last;
        logic [DATA_W-1:0] data;
    } beat_t;

    logic                 aclk;
    logic                 arst_n;
    logic                 aclken;
    logic [ADDR_W-1:0]    addr;
    logic [INFO_W-1:0]    in_info;
    logic                 s00_tvalid;
    logic [DATA_W-1:0]    s00_tdata;
    logic                 s00_tlast;
    logic [USER_W-1:0]    s00_tuser;
    logic [KEEP_W-1:0]    s00_tkeep;
    logic                 s00_tready;
    logic [INFO_W-1:0]    out_info  [NUM_PORTS];
    logic [NUM_PORTS-1:0] m00_tvalid;
    logic [DATA_W-1:0]    m00_tdata [NUM_PORTS];
    logic [NUM_PORTS-1:0] m00_tlast;
    logic [USER_W-1:0]    m00_tuser [NUM_PORTS];
    logic [KEEP_W-1:0]    m00_tkeep [NUM_PORTS];
    logic [NUM_PORTS-1:0] m00_tready;

    logic [31:0]          lfsr_state;
    bit                   rand_ready;   // random m ready per cycle
    bit                   rand_gaps;    // random aclken low cycles
    logic [NUM_PORTS-1:0] fixed_ready;  // used when rand_ready is off
    logic                 en_level;     // used when rand_gaps is off

    beat_t                exp_q [NUM_PORTS][$];
    logic                 mon_in_pkt;   // input side packet state
    logic [ADDR_W-1:0]    mon_addr;     // first-beat addr of the open packet
    int                   sent_count;
    int                   recv_count;

    // snapshot taken at an edge with aclken low
    logic                 gap_edge;
    logic [NUM_PORTS-1:0] snap_valid;
    logic [NUM_PORTS-1:0] snap_last;
    logic                 snap_ready;
    logic [DATA_W-1:0]    snap_data [NUM_PORTS];
    logic [USER_W-1:0]    snap_user [NUM_PORTS];
    logic [KEEP_W-1:0]    snap_keep [NUM_PORTS];
    logic [INFO_W-1:0]    snap_info [NUM_PORTS];

    axis_route_top dut0 (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .aclken     (aclken),
        .addr       (addr),
        .in_info    (in_info),
        .s00_tvalid (s00_tvalid),
        .s00_tdata  (s00_tdata),
        .s00_tlast  (s00_tlast),
        .s00_tuser  (s00_tuser),
        .s00_tkeep  (s00_tkeep),
        .s00_tready (s00_tready),
        .out_info   (out_info),
        .m00_tvalid (m00_tvalid),
        .m00_tdata  (m00_tdata),
        .m00_tlast  (m00_tlast),
        .m00_tuser  (m00_tuser),
        .m00_tkeep  (m00_tkeep),
        .m00_tready (m00_tready)
    );

    always #50 aclk = ~aclk;    // 100 ns period

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // expected beat goes to the packet's first-beat addr
    function automatic beat_t route_ref(input logic [ADDR_W-1:0] first_addr,
                                        input logic [DATA_W-1:0] data,
                                        input logic last,
                                        input logic [USER_W-1:0] user,
                                        input logic [KEEP_W-1:0] keep,
                                        input logic [INFO_W-1:0] info);
        beat_t b;
        b.port = first_addr;
        b.data = data;
        b.last = last;
        b.user = user;
        b.keep = keep;
        b.info = info;
        return b;
    endfunction

    function automatic bit queues_empty();
        bit e;
        e = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (exp_q[p].size() != 0) e = 1'b0;
        end
        return e;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        assert (want === got) else
            stop_run($sformatf("ERR time=%0t %s expected=%0h actual=%0h",
                               $time, name, want, got));
    endtask

    // one clock edge and the next ready and aclken values
    task automatic tick(output logic took);
        @(posedge aclk);
        took = aclken & s00_tvalid & s00_tready;    // pre-edge values
        if (rand_ready) m00_tready <= NUM_PORTS'(rand_bits(NUM_PORTS));
        else            m00_tready <= fixed_ready;
        if (rand_gaps) aclken <= (rand_bits(3) != 0);   // about 1 in 8 low
        else           aclken <= en_level;
    endtask

    // new beat at s00 with addr random on every beat
    task automatic drive_beat(input logic last);
        s00_tvalid <= 1'b1;
        s00_tdata  <= DATA_W'(rand_bits(DATA_W));
        s00_tlast  <= last;
        s00_tuser  <= USER_W'(rand_bits(USER_W));
        s00_tkeep  <= KEEP_W'(rand_bits(KEEP_W));
        in_info    <= INFO_W'(rand_bits(INFO_W));
        addr       <= ADDR_W'(rand_bits(ADDR_W));
    endtask

    task automatic wait_accept();
        logic took;
        int   waited;
        took   = 1'b0;
        waited = 0;
        while (!took) begin
            tick(took);
            waited++;
            if (waited > 200) stop_run("timeout waiting for s00 to accept a beat");
        end
    endtask

    task automatic send_beat(input logic last);
        drive_beat(last);
        wait_accept();
    endtask

    task automatic send_packet();
        int len;
        len = 1 + int'(rand_bits(3) % 6);   // 1 to 6 beats
        for (int i = 0; i < len; i++) begin
            send_beat(i == len - 1);
        end
    endtask

    // all readies high until every port is empty
    task automatic drain();
        logic took;
        int   waited;
        s00_tvalid  <= 1'b0;
        rand_ready  = 1'b0;
        rand_gaps   = 1'b0;
        fixed_ready = '1;
        en_level    = 1'b1;
        waited      = 0;
        while (!(queues_empty() && m00_tvalid == '0)) begin
            tick(took);
            waited++;
            if (waited > 100) stop_run("timeout waiting for master ports to drain");
        end
        @(negedge aclk);
    endtask

    // blocked ports fill both slices, then s00 ready drops
    task automatic stall_check();
        logic took;
        int   idle;
        int   accepted;
        int   b;
        int   waited;
        rand_ready  = 1'b0;
        rand_gaps   = 1'b0;
        en_level    = 1'b1;
        fixed_ready = '0;
        tick(took);
        accepted = 0;
        idle     = 0;
        b        = 0;
        waited   = 0;
        drive_beat(1'b0);
        while (idle < 10) begin
            tick(took);
            waited++;
            if (waited > 50) stop_run("timeout waiting for s00 ready to fall while blocked");
            if (took) begin
                accepted++;
                b++;
                idle = 0;
                drive_beat(b == 5);
            end else begin
                idle++;
            end
        end
        @(negedge aclk);
        check_value("s00_tready", 32'd0, 32'(s00_tready));  // two slices of two
        check_value("beats accepted while blocked", 32'd4, accepted);
        fixed_ready = '1;
        wait_accept();          // fifth beat goes once ready returns
        send_beat(1'b1);
    endtask

    // input side pushes the reference result onto the chosen port's queue
    always @(posedge aclk) begin : in_monitor
        beat_t want;
        if (arst_n && aclken && s00_tvalid && s00_tready) begin
            if (!mon_in_pkt) mon_addr = addr;   // lock on first beat
            want = route_ref(mon_addr, s00_tdata, s00_tlast, s00_tuser,
                             s00_tkeep, in_info);
            exp_q[want.port].push_back(want);
            mon_in_pkt = !s00_tlast;
            sent_count++;
        end
    end

    // output side pops and compares on every transfer
    always @(posedge aclk) begin : out_compare
        beat_t want;
        if (arst_n && aclken) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (m00_tvalid[p] && m00_tready[p]) begin
                    assert (exp_q[p].size() > 0) else
                        stop_run($sformatf("port %0d delivered a beat nobody sent there", p));
                    want = exp_q[p].pop_front();
                    check_value($sformatf("m00_tdata[%0d]", p), 32'(want.data),
                                32'(m00_tdata[p]));
                    check_value($sformatf("m00_tlast[%0d]", p), 32'(want.last),
                                32'(m00_tlast[p]));
                    check_value($sformatf("m00_tuser[%0d]", p), 32'(want.user),
                                32'(m00_tuser[p]));
                    check_value($sformatf("m00_tkeep[%0d]", p), 32'(want.keep),
                                32'(m00_tkeep[p]));
                    check_value($sformatf("out_info[%0d]", p), 32'(want.info),
                                32'(out_info[p]));
                    recv_count++;
                end
            end
        end
    end

    // outputs before the edge for the hold check
    always @(posedge aclk) begin
        gap_edge   <= arst_n & ~aclken;
        snap_valid <= m00_tvalid;
        snap_last  <= m00_tlast;
        snap_ready <= s00_tready;
        for (int p = 0; p < NUM_PORTS; p++) begin
            snap_data[p] <= m00_tdata[p];
            snap_user[p] <= m00_tuser[p];
            snap_keep[p] <= m00_tkeep[p];
            snap_info[p] <= out_info[p];
        end
    end

    // nothing may move across an edge with aclken low
    always @(negedge aclk) begin
        if (gap_edge) begin
            check_value("m00_tvalid", 32'(snap_valid), 32'(m00_tvalid));
            check_value("m00_tlast", 32'(snap_last), 32'(m00_tlast));
            check_value("s00_tready", 32'(snap_ready), 32'(s00_tready));
            for (int p = 0; p < NUM_PORTS; p++) begin
                check_value($sformatf("m00_tdata[%0d]", p), 32'(snap_data[p]),
                            32'(m00_tdata[p]));
                check_value($sformatf("m00_tuser[%0d]", p), 32'(snap_user[p]),
                            32'(m00_tuser[p]));
                check_value($sformatf("m00_tkeep[%0d]", p), 32'(snap_keep[p]),
                            32'(m00_tkeep[p]));
                check_value($sformatf("out_info[%0d]", p), 32'(snap_info[p]),
                            32'(out_info[p]));
            end
        end
    end

    initial begin : main
        logic took;
        aclk        = 1'b0;
        arst_n      = 1'b0;
        aclken      = 1'b0;
        addr        = '0;
        in_info     = '0;
        s00_tvalid  = 1'b0;
        s00_tdata   = '0;
        s00_tlast   = 1'b0;
        s00_tuser   = '0;
        s00_tkeep   = '0;
        m00_tready  = '0;
        lfsr_state  = SEED;
        rand_ready  = 1'b0;
        rand_gaps   = 1'b0;
        fixed_ready = '0;
        en_level    = 1'b0;
        mon_in_pkt  = 1'b0;
        mon_addr    = '0;
        sent_count  = 0;
        recv_count  = 0;

        // reset for 4 edges with outputs quiet
        repeat (3) begin
            tick(took);
            @(negedge aclk);
            check_value("m00_tvalid", 32'd0, 32'(m00_tvalid));
            check_value("s00_tready", 32'd0, 32'(s00_tready));
        end
        tick(took);
        arst_n <= 1'b1;

        // out of reset with aclken still low
        repeat (2) begin
            tick(took);
            @(negedge aclk);
            check_value("s00_tready", 32'd0, 32'(s00_tready));
        end
        en_level = 1'b1;
        tick(took);             // aclken rises after this edge
        @(negedge aclk);
        check_value("s00_tready", 32'd0, 32'(s00_tready));
        tick(took);             // first enabled edge
        @(negedge aclk);
        check_value("s00_tready", 32'd1, 32'(s00_tready));
        check_value("m00_tvalid", 32'd0, 32'(m00_tvalid));

        stall_check();
        drain();

        // random traffic with back-pressure and gaps
        rand_ready = 1'b1;
        rand_gaps  = 1'b1;
        repeat (40) send_packet();
        drain();

        // single-beat packets at full rate
        fixed_ready = '1;
        repeat (100) send_beat(1'b1);
        drain();

        if (queues_empty() && sent_count == recv_count && sent_count > 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_run("beats left undelivered at end of run");
        end
    end

endmodule

// ==== filelist.f ====
axis_pkg.sv
route_pkg.sv
pipe_skid_buffer.sv
data_pipe_interconnect_s2m.sv
axis_interconnect_s2m_with_info.sv
axis_route_top.sv
tb_axis_route.sv
